// ==== Makefile ====
# Verilator build and run for the convolution datapath

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = conv_loop_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/conv_loop_assert.sv ====
`timescale 1ns/10ps

module conv_loop_assert #(
	parameter int REPLAY_LEN = 256
) (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic valid_in,
	input logic out_valid
);

	// Cycles that busy has been high in a row
	int busy_len;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_len <= 0;
		end else if (busy) begin
			busy_len <= busy_len + 1;
		end else begin
			busy_len <= 0;
		end
	end

	// Last result leaves three cycles after the last beat
	property quiet_when_idle;
		@(posedge clk) disable iff (reset)
		(!busy && !$past(busy) && !$past(busy, 2) && !$past(busy, 3)) |-> !out_valid;
	endproperty

	property idle_after_reset;
		@(posedge clk) reset |=> (!busy && !out_valid);
	endproperty

	// Busy only drops after the whole replay and the final beat
	property busy_holds_on_input;
		@(posedge clk) disable iff (reset)
		(busy && valid_in) |=> (busy || (busy_len == REPLAY_LEN + 1));
	endproperty

	a_quiet_when_idle: assert property (quiet_when_idle)
		else $error("out_valid high while busy was low for four cycles");
	a_idle_after_reset: assert property (idle_after_reset)
		else $error("busy or out_valid high right after reset");
	a_busy_holds: assert property (busy_holds_on_input)
		else $error("valid_in during busy changed busy");

endmodule

bind conv_loop_top conv_loop_assert #(
	.REPLAY_LEN(CH_OUT * CH_IN * IMAGE_WIDTH * IMAGE_WIDTH)
) u_assert (
	.clk      (clk),
	.reset    (reset),
	.busy     (busy),
	.valid_in (valid_in),
	.out_valid(out_valid)
);

// ==== tb/conv_loop_tb.sv ====
`timescale 1ns/10ps

module conv_loop_tb;
	import conv_data_pkg::*;

	localparam int IMAGE_WIDTH = 8;
	localparam int CH_IN       = 2;
	localparam int CH_OUT      = 2;
	localparam int OUT_W       = IMAGE_WIDTH - 2;
	localparam int NUM_OUT     = CH_OUT * OUT_W * OUT_W;
	localparam int FRAME       = CH_IN * IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int NUM_COEF    = CH_OUT * CH_IN * 9;
	localparam int COEF_AW     = $clog2(NUM_COEF);
	localparam int NUM_FRAMES  = 8;
	// Twice the load and replay time of every frame, plus slack
	localparam int CYCLE_LIMIT = 2 * NUM_FRAMES * (FRAME + NUM_COEF + CH_OUT * FRAME) + 100;

	logic               clk;
	logic               reset;
	logic               valid_in;
	pixel_t             pixel_in;
	logic               coef_we;
	logic [COEF_AW-1:0] coef_addr;
	coef_t              coef_data;
	logic               busy;
	logic               out_valid;
	acc_t               out_data;

	pixel_t      frame_mem [FRAME];
	coef_t       coef_mem [NUM_COEF];
	acc_t        exp_q [$];
	acc_t        got_q [$];
	acc_t        first_q [$];
	logic [15:0] lfsr;
	int          cycles = 0;
	int          err_cnt = 0;
	int          test_err;
	int          out_cnt;
	int          total_out = 0;
	int          tests = 0;
	int          busy_cycles = 0;

	conv_loop_top #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN      (CH_IN),
		.CH_OUT     (CH_OUT)
	) u_dut (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pixel_in (pixel_in),
		.coef_we  (coef_we),
		.coef_addr(coef_addr),
		.coef_data(coef_data),
		.busy     (busy),
		.out_valid(out_valid),
		.out_data (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no end of run after %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output logic [7:0] v);
		v = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	task automatic fill_random();
		logic [7:0] b;
		for (int i = 0; i < FRAME; i++) begin
			random_byte(b);
			frame_mem[i] = b;
		end
		for (int i = 0; i < NUM_COEF; i++) begin
			random_byte(b);
			coef_mem[i] = b;
		end
	endtask

	task automatic fill_const(input pixel_t p, input coef_t w);
		foreach (frame_mem[i]) frame_mem[i] = p;
		foreach (coef_mem[i]) coef_mem[i] = w;
	endtask

	// Valid windows only, summed over input channels, order oc, row, col
	function automatic void compute_reference();
		acc_t sum;
		int   pa;
		int   wa;
		exp_q.delete();
		for (int oc = 0; oc < CH_OUT; oc++) begin
			for (int r = 0; r < OUT_W; r++) begin
				for (int c = 0; c < OUT_W; c++) begin
					sum = 0;
					for (int ic = 0; ic < CH_IN; ic++) begin
						for (int kr = 0; kr < 3; kr++) begin
							for (int kc = 0; kc < 3; kc++) begin
								pa = (ic * IMAGE_WIDTH + r + kr) * IMAGE_WIDTH + c + kc;
								wa = ((oc * CH_IN + ic) * 3 + kr) * 3 + kc;
								sum += acc_t'(frame_mem[pa]) * acc_t'(coef_mem[wa]);
							end
						end
					end
					exp_q.push_back(sum);
				end
			end
		end
	endfunction

	task automatic write_coefs();
		for (int i = 0; i < NUM_COEF; i++) begin
			coef_we   = 1'b1;
			coef_addr = COEF_AW'(i);
			coef_data = coef_mem[i];
			@(posedge clk);
			#1;
		end
		coef_we = 1'b0;
	endtask

	// gap_every of zero loads back to back
	task automatic load_frame(input int gap_every);
		for (int i = 0; i < FRAME; i++) begin
			if (gap_every > 0 && (i % gap_every) == gap_every - 1) begin
				valid_in = 1'b0;
				@(posedge clk);
				#1;
			end
			valid_in = 1'b1;
			pixel_in = frame_mem[i];
			@(posedge clk);
			#1;
		end
		valid_in = 1'b0;
		// Busy rises on the cycle after the last pixel
		check_value("busy", busy, 32'd1);
	endtask

	task automatic wait_done();
		while (!busy) begin
			@(posedge clk);
			#1;
		end
		while (busy) begin
			@(posedge clk);
			#1;
		end
		// Pipeline drain behind the last beat
		repeat (4) @(posedge clk);
		#1;
		if (exp_q.size() != 0) begin
			$display("Missing outputs: %0d expected results never appeared", exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
	endtask

	task automatic run_frame(input int gap_every);
		compute_reference();
		write_coefs();
		load_frame(gap_every);
		wait_done();
	endtask

	////////////////////
	// Checking
	////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			err_cnt++;
		end
	endtask

	always @(negedge clk) begin
		if (!reset && out_valid) begin
			got_q.push_back(out_data);
			out_cnt++;
			total_out++;
			if (exp_q.size() == 0) begin
				$display("Unexpected output: out_valid with no result left to expect");
				err_cnt++;
			end else begin
				check_value("out_data", out_data, exp_q.pop_front());
			end
		end
	end

	// One cycle before the first beat, then one per replayed beat
	always @(negedge clk) begin
		if (reset) begin
			busy_cycles = 0;
		end else if (busy) begin
			busy_cycles++;
		end else if (busy_cycles != 0) begin
			check_value("busy length", busy_cycles, CH_OUT * FRAME + 1);
			busy_cycles = 0;
		end
	end

	task automatic start_test();
		out_cnt  = 0;
		test_err = err_cnt;
		got_q.delete();
	endtask

	task automatic end_test(input string name, input int expected);
		check_value("output count", out_cnt, expected);
		$display("%s: %0d outputs, %0d errors", name, out_cnt, err_cnt - test_err);
		tests++;
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		logic [7:0] b;
		reset     = 1'b1;
		valid_in  = 1'b0;
		pixel_in  = '0;
		coef_we   = 1'b0;
		coef_addr = '0;
		coef_data = '0;
		lfsr      = 16'd30;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test();
		fill_random();
		run_frame(0);
		end_test("Random frame", NUM_OUT);

		// Same frame twice, the second time with idle gaps
		start_test();
		fill_random();
		run_frame(0);
		first_q = got_q;
		got_q.delete();
		run_frame(3);
		if (got_q.size() != first_q.size()) begin
			$display("Gapped load gave %0d results, back to back gave %0d",
				got_q.size(), first_q.size());
			err_cnt++;
		end else begin
			foreach (got_q[i]) check_value("out_data gapped", got_q[i], first_q[i]);
		end
		end_test("Gapped load", 2 * NUM_OUT);

		start_test();
		fill_const(-8'sd128, -8'sd128);
		run_frame(0);
		fill_const(8'sd127, 8'sd127);
		run_frame(0);
		end_test("Extreme values", 2 * NUM_OUT);

		// Centre tap of oc 0, ic 0 passes channel 0 straight through
		start_test();
		fill_random();
		foreach (coef_mem[i]) coef_mem[i] = '0;
		coef_mem[4] = 8'sd1;
		run_frame(0);
		if (got_q.size() >= OUT_W * OUT_W) begin
			for (int i = 0; i < OUT_W * OUT_W; i++) begin
				check_value("out_data interior", got_q[i],
					acc_t'(frame_mem[(i / OUT_W + 1) * IMAGE_WIDTH + i % OUT_W + 1]));
			end
		end
		end_test("One-hot weights", NUM_OUT);

		// Inputs and weight writes during replay must be ignored
		start_test();
		fill_random();
		compute_reference();
		write_coefs();
		load_frame(0);
		while (!busy) begin
			@(posedge clk);
			#1;
		end
		for (int i = 0; i < 40; i++) begin
			random_byte(b);
			valid_in  = 1'b1;
			pixel_in  = b;
			coef_we   = 1'b1;
			coef_addr = COEF_AW'(i % NUM_COEF);
			coef_data = ~b;
			@(posedge clk);
			#1;
		end
		valid_in = 1'b0;
		coef_we  = 1'b0;
		wait_done();
		fill_random();
		run_frame(0);
		end_test("Input during replay", 2 * NUM_OUT);

		$display("Tests: %0d, outputs: %0d, errors: %0d", tests, total_out, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/coef_bank.sv ====
`timescale 1ns/10ps

module coef_bank #(
	parameter int  CH_IN    = 2,
	parameter int  CH_OUT   = 2,
	localparam int KSQ      = conv_ctrl_pkg::KERNEL_SIZE * conv_ctrl_pkg::KERNEL_SIZE,
	localparam int NUM_COEF = CH_OUT * CH_IN * KSQ,
	localparam int COEF_AW  = $clog2(NUM_COEF),
	localparam int IC_W     = (CH_IN > 1) ? $clog2(CH_IN) : 1,
	localparam int OC_W     = (CH_OUT > 1) ? $clog2(CH_OUT) : 1
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 busy,
	input  logic                 coef_we,
	input  logic [COEF_AW-1:0]   coef_addr,
	input  conv_data_pkg::coef_t coef_data,
	input  logic [OC_W-1:0]      oc,
	input  logic [IC_W-1:0]      ic,
	output conv_data_pkg::coef_t weights [conv_ctrl_pkg::KERNEL_SIZE][conv_ctrl_pkg::KERNEL_SIZE]
);
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;

	// Layout is oc, ic, kernel row, kernel column
	coef_t mem [NUM_COEF];

	// First weight of the selected kernel
	int base;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_COEF; i++) begin
				mem[i] <= '0;
			end
		end else if (coef_we && !busy && (int'(coef_addr) < NUM_COEF)) begin
			mem[coef_addr] <= coef_data;
		end
	end

	assign base = (int'(oc) * CH_IN + int'(ic)) * KSQ;

	always_comb begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				weights[r][c] = mem[base + r * KERNEL_SIZE + c];
			end
		end
	end

endmodule

// ==== verilog/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

	////////////////////
	// Kernel geometry
	////////////////////

	// Side length of the square kernel
	// Also the number of kernel-row lanes
	localparam int KERNEL_SIZE = 3;

	////////////////////
	// Replay buffer FSM
	////////////////////

	// Load one frame, then stream it once per output channel
	typedef enum logic {
		ST_LOAD   = 1'b0,
		ST_REPLAY = 1'b1
	} replay_state_t;

endpackage

// ==== verilog/conv_data_pkg.sv ====
package conv_data_pkg;

	////////////////////
	// Datapath widths
	////////////////////

	// Feature-map pixel, signed 8-bit
	typedef logic signed [7:0] pixel_t;

	// Kernel weight, signed 8-bit
	typedef logic signed [7:0] coef_t;

	// Three pixel-by-weight products summed
	// 16-bit products, two bits of growth, headroom on top
	typedef logic signed [19:0] row_sum_t;

	// Partial sums across input channels and the final result
	typedef logic signed [31:0] acc_t;

endpackage

// ==== verilog/conv_loop_top.sv ====
`timescale 1ns/10ps

module conv_loop_top #(
	parameter int  IMAGE_WIDTH = 8,
	parameter int  CH_IN       = 2,
	parameter int  CH_OUT      = 2,
	localparam int COEF_AW     = $clog2(CH_OUT * CH_IN
		* conv_ctrl_pkg::KERNEL_SIZE * conv_ctrl_pkg::KERNEL_SIZE)
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pixel_in,
	input  logic                  coef_we,
	input  logic [COEF_AW-1:0]    coef_addr,
	input  conv_data_pkg::coef_t  coef_data,
	output logic                  busy,
	output logic                  out_valid,
	output conv_data_pkg::acc_t   out_data
);
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;

	pixel_tap_if #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN      (CH_IN),
		.CH_OUT     (CH_OUT)
	) tap ();

	coef_t    weights [KERNEL_SIZE][KERNEL_SIZE];
	pixel_t   lane_pixel [KERNEL_SIZE+1];
	logic     lane_valid [KERNEL_SIZE+1];
	row_sum_t lane_sum [KERNEL_SIZE];

	fmap_replay_buffer #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN      (CH_IN),
		.CH_OUT     (CH_OUT)
	) u_buffer (
		.clk     (clk),
		.reset   (reset),
		.valid_in(valid_in),
		.pixel_in(pixel_in),
		.busy    (busy),
		.tap     (tap)
	);

	coef_bank #(
		.CH_IN (CH_IN),
		.CH_OUT(CH_OUT)
	) u_coef (
		.clk      (clk),
		.reset    (reset),
		.busy     (busy),
		.coef_we  (coef_we),
		.coef_addr(coef_addr),
		.coef_data(coef_data),
		.oc       (tap.oc),
		.ic       (tap.ic),
		.weights  (weights)
	);

	////////////////////
	// Kernel-row lanes
	////////////////////
	assign lane_valid[0] = tap.valid;
	assign lane_pixel[0] = tap.pixel;

	// Lane 0 holds the newest row, so it takes the bottom kernel row
	for (genvar k = 0; k < KERNEL_SIZE; k++) begin : g_lane
		kernel_row_lane #(
			.IMAGE_WIDTH(IMAGE_WIDTH)
		) u_lane (
			.clk        (clk),
			.reset      (reset),
			.in_valid   (lane_valid[k]),
			.in_pixel   (lane_pixel[k]),
			.row_weights(weights[KERNEL_SIZE-1-k]),
			.out_valid  (lane_valid[k+1]),
			.out_pixel  (lane_pixel[k+1]),
			.row_sum    (lane_sum[k])
		);
	end

	psum_accumulator #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN      (CH_IN)
	) u_acc (
		.clk      (clk),
		.reset    (reset),
		.tap      (tap),
		.row_sums (lane_sum),
		.out_valid(out_valid),
		.out_data (out_data)
	);

endmodule

// ==== verilog/fmap_replay_buffer.sv ====
`timescale 1ns/10ps

module fmap_replay_buffer #(
	parameter int IMAGE_WIDTH = 8,
	parameter int CH_IN       = 2,
	parameter int CH_OUT      = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pixel_in,
	output logic                  busy,
	pixel_tap_if.src              tap
);
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int FRAME_SIZE = CH_IN * IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int ADDR_W     = (FRAME_SIZE > 1) ? $clog2(FRAME_SIZE) : 1;
	localparam int POS_W      = (IMAGE_WIDTH > 1) ? $clog2(IMAGE_WIDTH) : 1;
	localparam int IC_W       = (CH_IN > 1) ? $clog2(CH_IN) : 1;
	localparam int OC_W       = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;

	// Whole input frame, channel-major
	pixel_t frame [FRAME_SIZE];

	replay_state_t     state;
	logic [ADDR_W-1:0] load_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic [POS_W-1:0]  col_cnt;
	logic [POS_W-1:0]  row_cnt;
	logic [IC_W-1:0]   ic_cnt;
	logic [OC_W-1:0]   oc_cnt;
	logic              load_en;
	logic              col_last;
	logic              row_last;
	logic              ic_last;
	logic              oc_last;

	// Busy also covers the last beat still in the output register
	assign busy    = (state == ST_REPLAY) || tap.valid;
	assign load_en = valid_in && !busy;

	assign col_last = (col_cnt == POS_W'(IMAGE_WIDTH - 1));
	assign row_last = (row_cnt == POS_W'(IMAGE_WIDTH - 1));
	assign ic_last  = (ic_cnt == IC_W'(CH_IN - 1));
	assign oc_last  = (oc_cnt == OC_W'(CH_OUT - 1));

	always_ff @(posedge clk) begin
		if (load_en) begin
			frame[load_addr] <= pixel_in;
		end
	end

	////////////////////
	// Load and replay FSM
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_LOAD;
			load_addr <= '0;
			rd_addr   <= '0;
			col_cnt   <= '0;
			row_cnt   <= '0;
			ic_cnt    <= '0;
			oc_cnt    <= '0;
		end else begin
			case (state)
				ST_LOAD: begin
					if (load_en) begin
						if (load_addr == ADDR_W'(FRAME_SIZE - 1)) begin
							load_addr <= '0;
							state     <= ST_REPLAY;
						end else begin
							load_addr <= load_addr + 1'b1;
						end
					end
				end
				ST_REPLAY: begin
					// Walk col, row, ic, oc; address wraps once per pass
					col_cnt <= col_last ? '0 : col_cnt + 1'b1;
					rd_addr <= (col_last && row_last && ic_last) ? '0 : rd_addr + 1'b1;
					if (col_last) begin
						row_cnt <= row_last ? '0 : row_cnt + 1'b1;
						if (row_last) begin
							ic_cnt <= ic_last ? '0 : ic_cnt + 1'b1;
							if (ic_last) begin
								oc_cnt <= oc_last ? '0 : oc_cnt + 1'b1;
								if (oc_last) begin
									state <= ST_LOAD;
								end
							end
						end
					end
				end
				default: state <= ST_LOAD;
			endcase
		end
	end

	// Read port, pixel and tags leave together one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			tap.valid <= 1'b0;
		end else begin
			tap.valid <= (state == ST_REPLAY);
		end
	end

	always_ff @(posedge clk) begin
		tap.pixel <= frame[rd_addr];
		tap.row   <= row_cnt;
		tap.col   <= col_cnt;
		tap.ic    <= ic_cnt;
		tap.oc    <= oc_cnt;
	end

endmodule

// ==== verilog/kernel_row_lane.sv ====
`timescale 1ns/10ps

module kernel_row_lane #(
	parameter int IMAGE_WIDTH = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  conv_data_pkg::pixel_t    in_pixel,
	input  conv_data_pkg::coef_t     row_weights [conv_ctrl_pkg::KERNEL_SIZE],
	output logic                     out_valid,
	output conv_data_pkg::pixel_t    out_pixel,
	output conv_data_pkg::row_sum_t  row_sum
);
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;

	// Shift line, one image row deep
	pixel_t                 line_buf [IMAGE_WIDTH];
	logic [IMAGE_WIDTH-1:0] line_vld;

	// Window taps, index 0 is the newest
	pixel_t   window [KERNEL_SIZE];
	row_sum_t dot;

	always_ff @(posedge clk) begin
		if (in_valid) begin
			line_buf[0] <= in_pixel;
			for (int i = 1; i < IMAGE_WIDTH; i++) begin
				line_buf[i] <= line_buf[i-1];
			end
		end
	end

	// Marks the line as filled for the next lane
	always_ff @(posedge clk) begin
		if (reset) begin
			line_vld <= '0;
		end else if (in_valid) begin
			line_vld <= {line_vld[IMAGE_WIDTH-2:0], 1'b1};
		end
	end

	assign out_pixel = line_buf[IMAGE_WIDTH-1];
	assign out_valid = in_valid && line_vld[IMAGE_WIDTH-1];

	// Head of the line doubles as the older taps
	always_comb begin
		window[0] = in_pixel;
		for (int i = 1; i < KERNEL_SIZE; i++) begin
			window[i] = line_buf[i-1];
		end
	end

	// Newest tap meets the last kernel column
	always_comb begin
		dot = '0;
		for (int i = 0; i < KERNEL_SIZE; i++) begin
			dot = dot + row_sum_t'(window[i]) * row_sum_t'(row_weights[KERNEL_SIZE-1-i]);
		end
	end

	always_ff @(posedge clk) begin
		row_sum <= dot;
	end

endmodule

// ==== verilog/pixel_tap_if.sv ====
`timescale 1ns/10ps

interface pixel_tap_if #(
	parameter int IMAGE_WIDTH = 8,
	parameter int CH_IN       = 2,
	parameter int CH_OUT      = 2
);
	import conv_data_pkg::*;

	// Tag widths, at least one bit each
	localparam int POS_W = (IMAGE_WIDTH > 1) ? $clog2(IMAGE_WIDTH) : 1;
	localparam int IC_W  = (CH_IN > 1) ? $clog2(CH_IN) : 1;
	localparam int OC_W  = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;

	// One replayed pixel and where it sits
	logic             valid;
	pixel_t           pixel;
	logic [POS_W-1:0] row;
	logic [POS_W-1:0] col;
	logic [IC_W-1:0]  ic;
	logic [OC_W-1:0]  oc;

	modport src (output valid, pixel, row, col, ic, oc);
	modport snk (input valid, pixel, row, col, ic, oc);

endinterface

// ==== verilog/psum_accumulator.sv ====
`timescale 1ns/10ps

module psum_accumulator #(
	parameter int IMAGE_WIDTH = 8,
	parameter int CH_IN       = 2
) (
	input  logic                    clk,
	input  logic                    reset,
	pixel_tap_if.snk                tap,
	input  conv_data_pkg::row_sum_t row_sums [conv_ctrl_pkg::KERNEL_SIZE],
	output logic                    out_valid,
	output conv_data_pkg::acc_t     out_data
);
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;

	localparam int POS_W    = (IMAGE_WIDTH > 1) ? $clog2(IMAGE_WIDTH) : 1;
	localparam int IC_W     = (CH_IN > 1) ? $clog2(CH_IN) : 1;
	localparam int OUT_W    = IMAGE_WIDTH - KERNEL_SIZE + 1;
	localparam int PS_DEPTH = OUT_W * OUT_W;
	localparam int PS_AW    = (PS_DEPTH > 1) ? $clog2(PS_DEPTH) : 1;

	// Tags one cycle late, in step with the lane sums
	logic             d_valid;
	logic [POS_W-1:0] d_row;
	logic [POS_W-1:0] d_col;
	logic [IC_W-1:0]  d_ic;
	logic             win_valid;
	logic [PS_AW-1:0] win_idx;
	acc_t             lane_total;

	// Accumulate stage
	logic             s2_valid;
	logic             s2_first;
	logic             s2_last;
	logic [PS_AW-1:0] s2_idx;
	acc_t             s2_sum;
	acc_t             total;

	// One partial sum per output pixel
	acc_t psum [PS_DEPTH];

	always_ff @(posedge clk) begin
		d_row <= tap.row;
		d_col <= tap.col;
		d_ic  <= tap.ic;
	end

	// Window fully inside one image of one channel
	assign win_valid = d_valid && (int'(d_row) >= KERNEL_SIZE - 1)
		&& (int'(d_col) >= KERNEL_SIZE - 1);
	assign win_idx = PS_AW'((int'(d_row) - (KERNEL_SIZE - 1)) * OUT_W
		+ int'(d_col) - (KERNEL_SIZE - 1));

	always_comb begin
		lane_total = '0;
		for (int k = 0; k < KERNEL_SIZE; k++) begin
			lane_total = lane_total + acc_t'(row_sums[k]);
		end
	end

	////////////////////
	// Control strobes
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			d_valid   <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			d_valid   <= tap.valid;
			s2_valid  <= win_valid;
			out_valid <= s2_valid && s2_last;
		end
	end

	always_ff @(posedge clk) begin
		s2_sum   <= lane_total;
		s2_idx   <= win_idx;
		s2_first <= (d_ic == '0);
		s2_last  <= (d_ic == IC_W'(CH_IN - 1));
	end

	// First input channel starts the sum fresh
	assign total = s2_first ? s2_sum : psum[s2_idx] + s2_sum;

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			psum[s2_idx] <= total;
		end
		if (s2_valid && s2_last) begin
			out_data <= total;
		end
	end

endmodule

// ==== vlog.f ====
verilog/conv_data_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/pixel_tap_if.sv
verilog/fmap_replay_buffer.sv
verilog/coef_bank.sv
verilog/kernel_row_lane.sv
verilog/psum_accumulator.sv
verilog/conv_loop_top.sv
tb/conv_loop_assert.sv
tb/conv_loop_tb.sv
